// ==== crc_settings.svh ====
// CRC-32 link constants shared by the RTL and the testbench; include wherever a macro is read
`ifndef CRC_SETTINGS_SVH
`define CRC_SETTINGS_SVH

// ethernet crc-32 generator polynomial
// x^32 term is implied and not stored
`define CRC_POLY 32'h04C11DB7

// register seed at the start of every frame
`define CRC_INIT 32'hFFFFFFFF

// crc register width in bits
`define CRC_W 32

// stream data width per valid beat
`define BYTE_W 8

// fcs length on the line, in bytes
// must equal CRC_W / BYTE_W
`define FCS_BYTES 4

`endif

// ==== crc_pkg.sv ====
// shared types of the CRC link: stream byte, CRC value, beat struct and transmit FSM states
`include "crc_settings.svh"

package crc_pkg;

    // one byte of the stream
    typedef logic [`BYTE_W-1:0] byte_t;

    // crc register, or a full fcs word
    typedef logic [`CRC_W-1:0] crc_t;

    // selects one fcs byte, lsb first
    typedef logic [$clog2(`FCS_BYTES)-1:0] fcs_idx_t;

    // receive delay line fill level, 0 up to FCS_BYTES
    typedef logic [$clog2(`FCS_BYTES+1)-1:0] fill_t;

    // one stream beat
    // valid travels beside it as its own wire
    typedef struct packed {
        byte_t data;
        // final byte of the frame
        logic  last;
    } beat_t;

    // fcs_append FSM
    // st_payload also covers idle between frames
    typedef enum logic {
        st_payload,
        st_fcs
    } append_state_e;

endpackage

// ==== lfsr_next.sv ====
// unrolled LFSR next-state network, one shift per data bit; instantiated by lfsr_crc or scramblers
`timescale 1ns/1ps

module lfsr_next #(
    // register width
    parameter int                LFSR_W  = 32,
    // feedback polynomial, top term implied
    parameter logic [LFSR_W-1:0] POLY    = 32'h04C11DB7,
    // seed used by the register around this network
    parameter logic [LFSR_W-1:0] INIT    = '1,
    // 1 galois (crc), 0 fibonacci (prbs, scrambler)
    parameter bit                GALOIS  = 1'b1,
    // lsb first on data and state when set
    parameter bit                REVERSE = 1'b1,
    // final inversion done by the owning crc register
    parameter bit                INVERT  = 1'b1,
    // shifts per evaluation
    parameter int                DATA_W  = 8
) (
    input  logic [DATA_W-1:0] data_in,
    input  logic [LFSR_W-1:0] state_in,
    output logic [LFSR_W-1:0] state_out,
    output logic [DATA_W-1:0] data_out
);

    // msb-first views of the inputs and results
    logic [LFSR_W-1:0] state_ord;
    logic [DATA_W-1:0] data_ord;
    logic [LFSR_W-1:0] next_ord;
    logic [DATA_W-1:0] dout_ord;

    // a prbs seeded with zero never leaves zero
    if (!GALOIS && INIT == '0) begin : g_chk_init
        $warning("fibonacci lfsr seeded with all zeros");
    end

    // inverted output only makes sense for a crc
    if (!GALOIS && INVERT) begin : g_chk_invert
        $warning("output inversion requested on a fibonacci lfsr");
    end

    // bring everything into msb-first order
    always_comb begin
        for (int i = 0; i < LFSR_W; i++) begin
            state_ord[i] = REVERSE ? state_in[LFSR_W-1-i] : state_in[i];
        end
        for (int i = 0; i < DATA_W; i++) begin
            data_ord[i] = REVERSE ? data_in[DATA_W-1-i] : data_in[i];
        end
    end

    // one single-bit shift per data bit, highest data bit first
    always_comb begin : p_shift
        logic [LFSR_W-1:0] s;
        logic              fb;
        s        = state_ord;
        fb       = 1'b0;
        dout_ord = '0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            if (GALOIS) begin
                // top bit leaves, poly folded back in where feedback is set
                fb          = s[LFSR_W-1] ^ data_ord[i];
                dout_ord[i] = s[LFSR_W-1];
                s           = {s[LFSR_W-2:0], 1'b0} ^ (fb ? POLY : '0);
            end else begin
                // taps summed into the new low bit
                // poly bit k taps stage k-1, constant term dropped
                fb          = data_ord[i] ^ s[LFSR_W-1]
                            ^ (^(s[LFSR_W-2:0] & POLY[LFSR_W-1:1]));
                dout_ord[i] = fb;
                s           = {s[LFSR_W-2:0], fb};
            end
        end
        next_ord = s;
    end

    // undo the reordering on the way out
    always_comb begin
        for (int i = 0; i < LFSR_W; i++) begin
            state_out[i] = REVERSE ? next_ord[LFSR_W-1-i] : next_ord[i];
        end
        for (int i = 0; i < DATA_W; i++) begin
            data_out[i] = REVERSE ? dout_ord[DATA_W-1-i] : dout_ord[i];
        end
    end

endmodule

// ==== lfsr_crc.sv ====
// clocked CRC register around lfsr_next; feed bytes with a valid strobe, read crc_out
`timescale 1ns/1ps

module lfsr_crc #(
    parameter int                LFSR_W  = 32,
    parameter logic [LFSR_W-1:0] POLY    = 32'h04C11DB7,
    // loaded on rst
    parameter logic [LFSR_W-1:0] INIT    = '1,
    parameter bit                GALOIS  = 1'b1,
    parameter bit                REVERSE = 1'b1,
    // invert crc_out
    parameter bit                INVERT  = 1'b1,
    parameter int                DATA_W  = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [DATA_W-1:0] data_in,
    input  logic              data_in_valid,
    output logic [LFSR_W-1:0] crc_out
);

    // running crc state
    logic [LFSR_W-1:0] state_q;
    // state after this beat
    logic [LFSR_W-1:0] state_nxt;

    lfsr_next #(
        .LFSR_W  (LFSR_W),
        .POLY    (POLY),
        .INIT    (INIT),
        .GALOIS  (GALOIS),
        .REVERSE (REVERSE),
        .INVERT  (INVERT),
        .DATA_W  (DATA_W)
    ) u_lfsr_next (
        .data_in   (data_in),
        .state_in  (state_q),
        .state_out (state_nxt),
        // shifted-out bits are a scrambler feature
        .data_out  ()
    );

    // rst restarts the crc, and wins over a beat on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= INIT;
        end else if (data_in_valid) begin
            state_q <= state_nxt;
        end
    end

    // only the inversion sits after the register
    assign crc_out = INVERT ? ~state_q : state_q;

endmodule

// ==== fcs_append.sv ====
// transmit side: passes payload bytes through and appends the 4-byte ethernet FCS, lsb first
`timescale 1ns/1ps
`include "crc_settings.svh"

module fcs_append import crc_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  beat_t tx_beat,
    input  logic  tx_valid,
    output beat_t line_beat,
    output logic  line_valid,
    output logic  tx_busy
);

    append_state_e state_q;
    // fcs byte currently being sent
    fcs_idx_t      idx_q;
    // remaining fcs bytes, shifted down each cycle
    crc_t          fcs_q;
    crc_t          fcs_src;
    crc_t          crc_val;
    logic          crc_clr;
    logic          take;
    logic          fcs_end;

    // payload only accepted outside the fcs tail
    assign take    = tx_valid && (state_q == st_payload);
    assign tx_busy = (state_q == st_fcs);
    assign fcs_end = (idx_q == fcs_idx_t'(`FCS_BYTES - 1));

    // crc sits at init during the tail, ready for the next frame
    assign crc_clr = rst || (state_q == st_fcs);

    // byte 0 straight from the crc, later bytes from the saved copy
    assign fcs_src = (idx_q == '0) ? crc_val : fcs_q;

    lfsr_crc #(
        .LFSR_W  (`CRC_W),
        .POLY    (`CRC_POLY),
        .INIT    (`CRC_INIT),
        .GALOIS  (1'b1),
        .REVERSE (1'b1),
        .INVERT  (1'b1),
        .DATA_W  (`BYTE_W)
    ) u_lfsr_crc (
        .clk           (clk),
        .rst           (crc_clr),
        .data_in       (tx_beat.data),
        .data_in_valid (take),
        .crc_out       (crc_val)
    );

    // control FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= st_payload;
            idx_q      <= '0;
            line_valid <= 1'b0;
        end else begin
            case (state_q)
                st_payload: begin
                    line_valid <= tx_valid;
                    if (tx_valid && tx_beat.last) begin
                        state_q <= st_fcs;
                    end
                end
                st_fcs: begin
                    // one fcs byte every cycle
                    line_valid <= 1'b1;
                    if (fcs_end) begin
                        state_q <= st_payload;
                        idx_q   <= '0;
                    end else begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= st_payload;
                end
            endcase
        end
    end

    // output stage and fcs shifter
    always_ff @(posedge clk) begin
        if (state_q == st_fcs) begin
            line_beat.data <= fcs_src[`BYTE_W-1:0];
            // last flag only on the final fcs byte
            line_beat.last <= fcs_end;
            fcs_q          <= fcs_src >> `BYTE_W;
        end else if (tx_valid) begin
            line_beat.data <= tx_beat.data;
            line_beat.last <= 1'b0;
        end
    end

    // upstream has no ready, it must respect busy
    a_idle_while_busy: assert property (
        @(posedge clk) disable iff (rst) tx_busy |-> !tx_valid
    ) else $error("tx beat offered while fcs tail in progress");

endmodule

// ==== fcs_check.sv ====
// receive side: holds back the trailing 4 bytes, runs the CRC over the payload, flags good/bad
`timescale 1ns/1ps
`include "crc_settings.svh"

module fcs_check import crc_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  beat_t rx_beat,
    input  logic  rx_valid,
    output logic  rx_done,
    output logic  rx_good
);

    // newest four bytes, oldest in the low byte
    crc_t  hold_q;
    fill_t fill_q;
    // result of the previous frame
    logic  good_q;
    crc_t  crc_val;
    logic  crc_clr;
    logic  crc_feed;
    logic  crc_match;

    // a byte leaving the full delay line is payload
    assign crc_feed = rx_valid && (fill_q == fill_t'(`FCS_BYTES));

    // restart after each frame, on the cycle of the report
    assign crc_clr = rst || rx_done;

    lfsr_crc #(
        .LFSR_W  (`CRC_W),
        .POLY    (`CRC_POLY),
        .INIT    (`CRC_INIT),
        .GALOIS  (1'b1),
        .REVERSE (1'b1),
        .INVERT  (1'b1),
        .DATA_W  (`BYTE_W)
    ) u_lfsr_crc (
        .clk           (clk),
        .rst           (crc_clr),
        .data_in       (hold_q[`BYTE_W-1:0]),
        .data_in_valid (crc_feed),
        .crc_out       (crc_val)
    );

    // delay line, shifts down so the fcs assembles lsb first
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            hold_q <= {rx_beat.data, hold_q[`CRC_W-1:`BYTE_W]};
        end
    end

    // fill count and done strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_q  <= '0;
            rx_done <= 1'b0;
        end else begin
            rx_done <= rx_valid && rx_beat.last;
            if (rx_valid && rx_beat.last) begin
                fill_q <= '0;
            end else if (rx_valid && fill_q != fill_t'(`FCS_BYTES)) begin
                fill_q <= fill_q + 1'b1;
            end
        end
    end

    // crc now includes the payload byte that left on the last beat
    assign crc_match = (crc_val == hold_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            good_q <= 1'b0;
        end else if (rx_done) begin
            good_q <= crc_match;
        end
    end

    // live compare during the report, held result afterwards
    assign rx_good = rx_done ? crc_match : good_q;

    // at least one payload byte ahead of the four fcs bytes
    a_min_len: assert property (
        @(posedge clk) disable iff (rst)
        (rx_valid && rx_beat.last) |-> (fill_q == fill_t'(`FCS_BYTES))
    ) else $error("rx frame shorter than five bytes");

endmodule

// ==== crc_link_top.sv ====
// CRC link top level: one FCS appender on transmit and one FCS checker on receive
`timescale 1ns/1ps

module crc_link_top import crc_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    // transmit stream in
    input  beat_t tx_beat,
    input  logic  tx_valid,
    // line out, payload plus fcs
    output beat_t line_beat,
    output logic  line_valid,
    output logic  tx_busy,
    // receive stream, fcs still attached
    input  beat_t rx_beat,
    input  logic  rx_valid,
    output logic  rx_done,
    output logic  rx_good
);

    // transmit path
    fcs_append u_fcs_append (
        .clk        (clk),
        .rst        (rst),
        .tx_beat    (tx_beat),
        .tx_valid   (tx_valid),
        .line_beat  (line_beat),
        .line_valid (line_valid),
        .tx_busy    (tx_busy)
    );

    // receive path
    // independent of transmit, looped outside
    fcs_check u_fcs_check (
        .clk      (clk),
        .rst      (rst),
        .rx_beat  (rx_beat),
        .rx_valid (rx_valid),
        .rx_done  (rx_done),
        .rx_good  (rx_good)
    );

endmodule

// ==== crc_link_tb.sv ====
// testbench top that runs known and random frames through crc_link_top with line loopback
`timescale 1ns/1ps
`include "crc_settings.svh"

module crc_link_tb import crc_pkg::*; ();

    localparam int CLK_HALF      = 50;
    localparam int DRIVE_DLY     = 10;
    localparam int RST_CYCLES    = 5;
    localparam int IDLE_CYCLES   = 10;
    // frame 0 fixed, 1..20 random, 21..26 alternate corrupt and clean
    localparam int NUM_FRAMES    = 27;
    localparam int FIRST_RANDOM  = 1;
    localparam int FIRST_CORRUPT = 21;
    localparam int NUM_TESTS     = 5;

    logic  clk;
    logic  rst;
    beat_t tx_beat;
    logic  tx_valid;
    beat_t line_beat;
    logic  line_valid;
    logic  tx_busy;
    beat_t rx_beat;
    logic  rx_valid;
    logic  rx_done;
    logic  rx_good;

    logic [31:0] rng_state = 32'd9156;
    int          wd_cycles = 0;
    string       check_str = "123456789";
    string       test_name [1:NUM_TESTS];
    int          err_cnt [1:NUM_TESTS];
    int          cur_test = 1;
    int          pass_tests = 0;
    int          fail_tests = 0;

    // per-frame setup
    int    frame_len [NUM_FRAMES];
    int    corrupt_beat [NUM_FRAMES];
    byte_t corrupt_mask [NUM_FRAMES];
    int    line_test [NUM_FRAMES];
    int    rx_test [NUM_FRAMES];
    bit    exp_good [NUM_FRAMES];

    // expected line beats and the test that owns each one
    beat_t exp_q[$];
    int    exp_test_q[$];
    int    frames_sent = 0;
    int    rx_count = 0;
    int    line_count = 0;

    crc_link_top u_crc_link_top (
        .clk        (clk),
        .rst        (rst),
        .tx_beat    (tx_beat),
        .tx_valid   (tx_valid),
        .line_beat  (line_beat),
        .line_valid (line_valid),
        .tx_busy    (tx_busy),
        .rx_beat    (rx_beat),
        .rx_valid   (rx_valid),
        .rx_done    (rx_done),
        .rx_good    (rx_good)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_next();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // bitwise reflected crc-32 one bit at a time
    function automatic crc_t crc32_ref(input byte_t data[$]);
        crc_t c;
        crc_t poly;
        crc_t rpoly;
        c    = `CRC_INIT;
        poly = `CRC_POLY;
        // lsb-first shifting needs the mirrored polynomial
        for (int i = 0; i < `CRC_W; i++) begin
            rpoly[i] = poly[`CRC_W - 1 - i];
        end
        foreach (data[k]) begin
            c = c ^ crc_t'(data[k]);
            for (int b = 0; b < `BYTE_W; b++) begin
                c = c[0] ? ((c >> 1) ^ rpoly) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    // lengths and corruption points for every frame up front
    task automatic pick_frames();
        int total;
        int n;
        total = 0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            frame_len[f]    = (f == 0) ? check_str.len() : int'(rand_next() % 32) + 1;
            corrupt_beat[f] = -1;
            corrupt_mask[f] = '0;
            line_test[f]    = (f == 0) ? 2 : ((f < FIRST_CORRUPT) ? 3 : 5);
            rx_test[f]      = (f < FIRST_CORRUPT) ? 4 : 5;
            n               = f - FIRST_CORRUPT;
            if (n >= 0 && n % 2 == 0) begin
                case (n / 2)
                    // a payload byte
                    0: corrupt_beat[f] = int'(rand_next() % frame_len[f]);
                    // any fcs byte
                    1: corrupt_beat[f] = frame_len[f] + int'(rand_next() % `FCS_BYTES);
                    // the final fcs byte that carries last
                    default: corrupt_beat[f] = frame_len[f] + `FCS_BYTES - 1;
                endcase
                corrupt_mask[f] = byte_t'(1) << (rand_next() % `BYTE_W);
            end
            exp_good[f] = (corrupt_beat[f] < 0);
            total += frame_len[f] + `FCS_BYTES + 6;
        end
        wd_cycles = 2 * total + RST_CYCLES + IDLE_CYCLES;
    endtask

    task automatic send_frame(input int f);
        byte_t data_q[$];
        crc_t  fcs;
        beat_t b;
        for (int i = 0; i < frame_len[f]; i++) begin
            if (f == 0) begin
                data_q.push_back(byte_t'(check_str[i]));
            end else begin
                data_q.push_back(byte_t'(rand_next()));
            end
        end
        fcs = crc32_ref(data_q);
        // payload unchanged then fcs lsb first with last on the final byte
        foreach (data_q[i]) begin
            b.data = data_q[i];
            b.last = 1'b0;
            exp_q.push_back(b);
            exp_test_q.push_back(line_test[f]);
        end
        for (int k = 0; k < `FCS_BYTES; k++) begin
            b.data = fcs[k*`BYTE_W +: `BYTE_W];
            b.last = (k == `FCS_BYTES - 1);
            exp_q.push_back(b);
            exp_test_q.push_back(line_test[f]);
        end
        frames_sent++;
        foreach (data_q[i]) begin
            tx_beat.data = data_q[i];
            tx_beat.last = (i == data_q.size() - 1);
            tx_valid     = 1'b1;
            @(posedge clk);
            #DRIVE_DLY;
        end
        tx_valid = 1'b0;
        tx_beat  = '0;
        // no ready on this bus so wait out the fcs tail
        while (tx_busy) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic send_frames(input int first_f, input int last_f);
        @(posedge clk);
        #DRIVE_DLY;
        for (int f = first_f; f <= last_f; f++) begin
            send_frame(f);
        end
        wait (rx_count == frames_sent);
        if (exp_q.size() != 0) begin
            $display("error [%s]: %0d expected line beats never appeared",
                     test_name[cur_test], exp_q.size());
            err_cnt[cur_test]++;
        end
    endtask

    task automatic report_test(input int t);
        if (err_cnt[t] == 0) begin
            $display("test %0d %s: pass", t, test_name[t]);
            pass_tests++;
        end else begin
            $display("test %0d %s: fail, %0d errors", t, test_name[t], err_cnt[t]);
            fail_tests++;
        end
    endtask

    // loopback with one bit flipped on the chosen beat
    initial begin : loopback
        int f;
        int pos;
        f   = 0;
        pos = 0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            rx_valid = line_valid;
            rx_beat  = line_valid ? line_beat : '0;
            if (line_valid === 1'b1 && f < NUM_FRAMES) begin
                if (pos == corrupt_beat[f]) begin
                    rx_beat.data = rx_beat.data ^ corrupt_mask[f];
                end
                if (line_beat.last) begin
                    f++;
                    pos = 0;
                end else begin
                    pos++;
                end
            end
        end
    end

    // compare line beats and rx reports mid-cycle
    always @(negedge clk) begin : compare
        beat_t exp_b;
        int    t;
        if (!rst && line_valid) begin
            if (exp_q.size() == 0) begin
                $display("error [%s]: line beat %0d appeared with no frame pending",
                         test_name[cur_test], line_count);
                err_cnt[cur_test]++;
            end else begin
                exp_b = exp_q.pop_front();
                t     = exp_test_q.pop_front();
                if (line_beat.data !== exp_b.data) begin
                    $display("** Error [%s] line beat %0d data: expected %02h, actual %02h",
                             test_name[t], line_count, exp_b.data, line_beat.data);
                    err_cnt[t]++;
                end
                if (line_beat.last !== exp_b.last) begin
                    $display("** Error [%s] line beat %0d last: expected %b, actual %b",
                             test_name[t], line_count, exp_b.last, line_beat.last);
                    err_cnt[t]++;
                end
            end
            line_count++;
        end
        if (!rst && tx_valid && tx_busy) begin
            $display("error [%s]: tx beat driven while tx_busy was high", test_name[cur_test]);
            err_cnt[cur_test]++;
        end
        if (!rst && rx_done) begin
            if (rx_count >= frames_sent) begin
                $display("error [%s]: rx_done pulsed with no frame outstanding",
                         test_name[cur_test]);
                err_cnt[cur_test]++;
            end else begin
                t = rx_test[rx_count];
                if (rx_good !== exp_good[rx_count]) begin
                    $display("** Error [%s] frame %0d rx_good: expected %b, actual %b",
                             test_name[t], rx_count, exp_good[rx_count], rx_good);
                    err_cnt[t]++;
                end
                rx_count++;
            end
        end
    end

    initial begin : watchdog
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired, tests did not finish within %0d cycles", wd_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main
        byte_t str_q[$];
        crc_t  ref_fcs;
        rst      = 1'b1;
        tx_beat  = '0;
        tx_valid = 1'b0;
        rx_beat  = '0;
        rx_valid = 1'b0;
        test_name[1] = "reset idle";
        test_name[2] = "check string fcs";
        test_name[3] = "random frames on line";
        test_name[4] = "clean loopback";
        test_name[5] = "corrupted loopback";
        for (int t = 1; t <= NUM_TESTS; t++) begin
            err_cnt[t] = 0;
        end
        pick_frames();

        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        // outputs must stay quiet with nothing offered
        cur_test = 1;
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            if ({line_valid, tx_busy, rx_done} !== 3'b000) begin
                $display("** Error [%s] line_valid tx_busy rx_done: expected 000, actual %b%b%b",
                         test_name[1], line_valid, tx_busy, rx_done);
                err_cnt[1]++;
            end
        end
        report_test(1);

        // known check value of the ethernet crc
        cur_test = 2;
        for (int i = 0; i < check_str.len(); i++) begin
            str_q.push_back(byte_t'(check_str[i]));
        end
        ref_fcs = crc32_ref(str_q);
        if (ref_fcs !== 32'hCBF43926) begin
            $display("** Error [%s] reference crc: expected %08h, actual %08h",
                     test_name[2], 32'hCBF43926, ref_fcs);
            err_cnt[2]++;
        end
        send_frames(0, 0);
        report_test(2);

        cur_test = 3;
        send_frames(FIRST_RANDOM, FIRST_CORRUPT - 1);
        report_test(3);
        report_test(4);

        cur_test = 5;
        send_frames(FIRST_CORRUPT, NUM_FRAMES - 1);
        report_test(5);

        $display("%0d of %0d tests passed, %0d failed", pass_tests, NUM_TESTS, fail_tests);
        if (fail_tests == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
crc_pkg.sv
lfsr_next.sv
lfsr_crc.sv
fcs_append.sv
fcs_check.sv
crc_link_top.sv
crc_link_tb.sv

// ==== Bender.yml ====
package:
  name: crc_link

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - crc_pkg.sv
      - lfsr_next.sv
      - lfsr_crc.sv
      - fcs_append.sv
      - fcs_check.sv
      - crc_link_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - crc_link_tb.sv
